// ==== mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

  localparam int xlen         = 64;
  localparam int regno_width  = 5;
  localparam int offset_width = 3;  // Byte offset within a line
  localparam int byte_width   = 8;

  typedef logic [xlen-1:0]        xword_t;
  typedef logic [regno_width-1:0] regno_t;

  typedef enum logic [3:0] {
    op_none,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    cmd_idle,
    cmd_read,
    cmd_write
  } cache_cmd_e;

  typedef struct packed {
    mem_op_e op;
    xword_t  alu_result;  // Also the physical address for memory ops
    xword_t  rs2_value;
    regno_t  rd_regno;
    logic    update_rd;
    logic    branch_taken;
    xword_t  pc_target;
  } stage_in_t;

  typedef struct packed {
    mem_op_e op;
    xword_t  alu_result;
    xword_t  rs2_value;
    regno_t  rd_regno;
    logic    update_rd;
    logic    branch_taken;
    xword_t  pc_target;
    xword_t  mdata;       // Load value, zero for everything else
  } stage_out_t;

  typedef struct packed {
    cache_cmd_e cmd;
    xword_t     addr;  // Line aligned
    xword_t     wdata;
  } cache_req_t;

  typedef struct packed {
    logic   read_done;
    logic   write_done;
    xword_t rdata;
  } cache_rsp_t;

  function automatic logic is_load(mem_op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  // Stores narrower than a line need a read first
  function automatic logic is_sub_store(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

endpackage

`default_nettype wire

// ==== load_align.sv ====
`default_nettype none

module load_align (
  input  mem_stage_pkg::mem_op_e                  op,
  input  logic [mem_stage_pkg::offset_width-1:0] offset,
  input  mem_stage_pkg::xword_t                  line,
  output mem_stage_pkg::xword_t                  value
);

  import mem_stage_pkg::*;

  logic [byte_width-1:0]   byte_lane;
  logic [2*byte_width-1:0] half_lane;
  logic [4*byte_width-1:0] word_lane;

  // Low offset bits are ignored below natural alignment
  assign byte_lane = line[offset*byte_width +: byte_width];
  assign half_lane = line[offset[offset_width-1:1]*2*byte_width +: 2*byte_width];
  assign word_lane = line[offset[offset_width-1]*4*byte_width +: 4*byte_width];

  always_comb begin
    case (op)
      op_lb: begin
        value = {{(xlen-byte_width){byte_lane[byte_width-1]}}, byte_lane};
      end
      op_lbu: begin
        value = {{(xlen-byte_width){1'b0}}, byte_lane};
      end
      op_lh: begin
        value = {{(xlen-2*byte_width){half_lane[2*byte_width-1]}}, half_lane};
      end
      op_lhu: begin
        value = {{(xlen-2*byte_width){1'b0}}, half_lane};
      end
      op_lw: begin
        value = {{(xlen-4*byte_width){word_lane[4*byte_width-1]}}, word_lane};
      end
      op_lwu: begin
        value = {{(xlen-4*byte_width){1'b0}}, word_lane};
      end
      op_ld: begin
        value = line;  // Whole line, no extension needed
      end
      default: begin
        value = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== store_merge.sv ====
`default_nettype none

module store_merge (
  input  mem_stage_pkg::mem_op_e                  op,
  input  logic [mem_stage_pkg::offset_width-1:0] offset,
  input  mem_stage_pkg::xword_t                  line,
  input  mem_stage_pkg::xword_t                  store_data,
  output mem_stage_pkg::xword_t                  merged
);

  import mem_stage_pkg::*;

  logic [offset_width-2:0] half_idx;
  logic                    word_idx;

  assign half_idx = offset[offset_width-1:1];
  assign word_idx = offset[offset_width-1];  // Word lane from address bit 2

  always_comb begin
    merged = line;  // Untouched lanes keep the old line
    case (op)
      op_sb: begin
        merged[offset*byte_width +: byte_width] = store_data[byte_width-1:0];
      end
      op_sh: begin
        merged[half_idx*2*byte_width +: 2*byte_width] =
          store_data[2*byte_width-1:0];
      end
      op_sw: begin
        merged[word_idx*4*byte_width +: 4*byte_width] =
          store_data[4*byte_width-1:0];
      end
      default: begin
        merged = line;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== access_ctrl.sv ====
`default_nettype none

module access_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  mem_stage_pkg::mem_op_e      op,
  input  mem_stage_pkg::xword_t       addr,
  input  mem_stage_pkg::xword_t       store_data,
  input  mem_stage_pkg::xword_t       merged_line,
  input  logic                        flush,
  output mem_stage_pkg::cache_req_t   cache_req,
  input  logic                        read_done,
  input  logic                        write_done,
  output logic                        ready
);

  import mem_stage_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } ctrl_state_e;

  ctrl_state_e state;
  ctrl_state_e state_next;
  xword_t      wdata_q;
  logic        mem_op;
  logic        load_op;
  logic        sub_store_op;

  assign load_op      = is_load(op);
  assign sub_store_op = is_sub_store(op);
  assign mem_op       = load_op || is_store(op);

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (load_op || sub_store_op) begin
          state_next = st_read;
        end else if (op == op_sd) begin
          state_next = st_write;  // Full line, no read needed
        end
      end
      st_read: begin
        if (read_done) begin
          state_next = load_op ? st_idle : st_write;
        end
      end
      st_write: begin
        if (write_done) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
    if (flush) begin
      state_next = st_idle;  // Drop whatever is in progress
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && op == op_sd) begin
      wdata_q <= store_data;
    end else if (state == st_read && read_done && sub_store_op) begin
      wdata_q <= merged_line;  // Old line with the store lane replaced
    end
  end

  always_comb begin
    cache_req.addr  = {addr[xlen-1:offset_width], {offset_width{1'b0}}};
    cache_req.wdata = wdata_q;
    case (state)
      st_read: begin
        cache_req.cmd = cmd_read;
      end
      st_write: begin
        cache_req.cmd = cmd_write;
      end
      default: begin
        cache_req.cmd = cmd_idle;
      end
    endcase
  end

  // Loads finish on the read, all stores on the write
  assign ready = flush
              || !mem_op
              || (state == st_read && read_done && load_op)
              || (state == st_write && write_done);

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

module mem_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  mem_stage_pkg::stage_in_t    stage_in,
  input  logic                        syscall_flush,
  output logic                        ready,
  output mem_stage_pkg::stage_out_t   stage_out,
  output mem_stage_pkg::cache_req_t   cache_req,
  input  mem_stage_pkg::cache_rsp_t   cache_rsp
);

  import mem_stage_pkg::*;

  logic [offset_width-1:0] offset;
  xword_t                  load_value;
  xword_t                  merged_line;

  assign offset = stage_in.alu_result[offset_width-1:0];

  access_ctrl i_access_ctrl (
    .clk         (clk),
    .reset       (reset),
    .op          (stage_in.op),
    .addr        (stage_in.alu_result),
    .store_data  (stage_in.rs2_value),
    .merged_line (merged_line),
    .flush       (syscall_flush),
    .cache_req   (cache_req),
    .read_done   (cache_rsp.read_done),
    .write_done  (cache_rsp.write_done),
    .ready       (ready)
  );

  load_align i_load_align (
    .op     (stage_in.op),
    .offset (offset),
    .line   (cache_rsp.rdata),
    .value  (load_value)
  );

  store_merge i_store_merge (
    .op         (stage_in.op),
    .offset     (offset),
    .line       (cache_rsp.rdata),
    .store_data (stage_in.rs2_value),
    .merged     (merged_line)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_out <= '0;
    end else if (syscall_flush) begin
      stage_out <= '0;  // Squash the instruction in this stage
    end else if (ready) begin
      stage_out.op           <= stage_in.op;
      stage_out.alu_result   <= stage_in.alu_result;
      stage_out.rs2_value    <= stage_in.rs2_value;
      stage_out.rd_regno     <= stage_in.rd_regno;
      stage_out.update_rd    <= stage_in.update_rd;
      stage_out.branch_taken <= stage_in.branch_taken;
      stage_out.pc_target    <= stage_in.pc_target;
      // rdata is valid here since ready on a load means read_done
      stage_out.mdata        <= is_load(stage_in.op) ? load_value : '0;
    end
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  localparam int half_period = 4;  // Period 8

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== mem_stage_properties.sv ====
`default_nettype none

module mem_stage_properties (
  input logic                      clk,
  input logic                      reset,
  input mem_stage_pkg::stage_in_t  stage_in,
  input logic                      syscall_flush,
  input mem_stage_pkg::cache_req_t cache_req,
  input mem_stage_pkg::cache_rsp_t cache_rsp
);

  import mem_stage_pkg::*;

  logic done;

  assign done = cache_rsp.read_done || cache_rsp.write_done;

  idle_after_reset: assert property (@(posedge clk)
    reset |=> cache_req.cmd == cmd_idle)
    else $error("Cache command not idle after reset");

  // Command held until its done pulse unless flushed
  cmd_stable: assert property (@(posedge clk) disable iff (reset)
    (cache_req.cmd != cmd_idle && !done && !syscall_flush)
      |=> $stable(cache_req.cmd) && $stable(cache_req.addr))
    else $error("Cache command or address changed before done");

  // Write of a sub-word store starts right after a read of the same line
  read_before_write: assert property (@(posedge clk) disable iff (reset)
    (cache_req.cmd == cmd_write && $past(cache_req.cmd) != cmd_write
      && stage_in.op != op_sd)
      |-> $past(cache_req.cmd) == cmd_read && $past(cache_rsp.read_done)
          && $past(cache_req.addr) == cache_req.addr)
    else $error("Sub-word store write without a preceding read");

endmodule

bind mem_stage mem_stage_properties i_mem_stage_properties (
  .clk           (clk),
  .reset         (reset),
  .stage_in      (stage_in),
  .syscall_flush (syscall_flush),
  .cache_req     (cache_req),
  .cache_rsp     (cache_rsp)
);

`default_nettype wire

// ==== tb_mem_stage.sv ====
`default_nettype none

module tb_mem_stage;

  import mem_stage_pkg::*;

  localparam int unsigned num_ops     = 400;
  localparam int unsigned cycle_limit = num_ops * 12;

  logic       clk;
  logic       reset;
  stage_in_t  stage_in;
  logic       syscall_flush;
  logic       ready;
  stage_out_t stage_out;
  cache_req_t cache_req;
  cache_rsp_t cache_rsp;

  xword_t      cache_mem [16];  // Contents behind the cache port
  xword_t      ref_mem [16];    // Reference copy
  stage_out_t  prev_out;
  cache_req_t  exp_write;
  int unsigned write_count;
  int unsigned out_errors;
  int unsigned write_errors;
  int unsigned other_errors;
  int unsigned cycle_count;

  logic        busy;
  int unsigned delay_left;
  logic        fire_read = 1'b0;
  logic        fire_write = 1'b0;
  xword_t      fire_data;

  tb_clock_gen i_clock_gen (
    .clk (clk)
  );

  mem_stage i_dut (
    .clk           (clk),
    .reset         (reset),
    .stage_in      (stage_in),
    .syscall_flush (syscall_flush),
    .ready         (ready),
    .stage_out     (stage_out),
    .cache_req     (cache_req),
    .cache_rsp     (cache_rsp)
  );

  function automatic int unsigned access_bytes(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic xword_t lane_mask(int unsigned nbytes);
    if (nbytes == 8) begin
      return '1;
    end
    return (64'd1 << (8 * nbytes)) - 64'd1;
  endfunction

  function automatic int unsigned lane_shift(mem_op_e op, logic [2:0] off);
    int unsigned n;
    n = access_bytes(op);
    return 8 * ((int'(off) / n) * n);  // Offset rounded down to the access size
  endfunction

  function automatic xword_t ref_load(mem_op_e op, logic [2:0] off, xword_t line);
    int unsigned n;
    xword_t      raw;
    n   = access_bytes(op);
    raw = (line >> lane_shift(op, off)) & lane_mask(n);
    if (op inside {op_lb, op_lh, op_lw} && ((raw >> (8 * n - 1)) & 64'd1) != 64'd0) begin
      raw = raw | ~lane_mask(n);
    end
    return raw;
  endfunction

  function automatic xword_t ref_store(mem_op_e op, logic [2:0] off, xword_t line,
                                       xword_t data);
    int unsigned n;
    int unsigned sh;
    n  = access_bytes(op);
    sh = lane_shift(op, off);
    return (line & ~(lane_mask(n) << sh)) | ((data & lane_mask(n)) << sh);
  endfunction

  task automatic check_stage_out(string name, stage_out_t expected, stage_out_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      out_errors++;
    end
  endtask

  task automatic check_write(string name, cache_req_t expected, cache_req_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      write_errors++;
    end
  endtask

  task automatic check_ready(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Fail %s ready: expected %b, actual %b", name, expected, actual);
      other_errors++;
    end
  endtask

  task automatic check_cmd(string name, cache_cmd_e expected, cache_cmd_e actual);
    if (actual !== expected) begin
      $display("Fail %s cmd: expected %s, actual %s", name, expected.name(), actual.name());
      other_errors++;
    end
  endtask

  // Cache model, decides at the falling edge and drives after the rising edge
  always @(negedge clk) begin
    fire_read  = 1'b0;
    fire_write = 1'b0;
    if (cache_rsp.write_done) begin
      check_write("cache write", exp_write, cache_req);
      cache_mem[cache_req.addr[6:3]] = cache_req.wdata;
      write_count++;
    end
    if (reset || syscall_flush || cache_req.cmd == cmd_idle
        || cache_rsp.read_done || cache_rsp.write_done) begin
      busy = 1'b0;
    end else begin
      if (!busy) begin
        busy       = 1'b1;
        delay_left = $urandom_range(1, 4);
      end
      delay_left--;
      if (delay_left == 0) begin
        busy       = 1'b0;
        fire_read  = (cache_req.cmd == cmd_read);
        fire_write = (cache_req.cmd == cmd_write);
        fire_data  = cache_mem[cache_req.addr[6:3]];
      end
    end
  end

  always @(posedge clk) begin
    #1;
    cache_rsp.read_done  = fire_read;
    cache_rsp.write_done = fire_write;
    cache_rsp.rdata      = fire_read ? fire_data : {$urandom, $urandom};  // Noise otherwise
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic run_op(input stage_in_t ins, input logic flush_it, input int unsigned num);
    stage_out_t  exp_out;
    xword_t      line;
    logic [3:0]  idx;
    logic [2:0]  off;
    logic        store_op;
    int unsigned writes_before;
    int unsigned writes_expected;
    string       name;
    name     = $sformatf("op %0d %s", num, ins.op.name());
    idx      = ins.alu_result[6:3];
    off      = ins.alu_result[2:0];
    line     = ref_mem[idx];
    store_op = ins.op inside {op_sb, op_sh, op_sw, op_sd};
    if (ins.op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld}) begin
      exp_out = {ins, ref_load(ins.op, off, line)};
    end else begin
      exp_out = {ins, 64'd0};
    end
    if (store_op) begin
      exp_write.cmd   = cmd_write;
      exp_write.addr  = {ins.alu_result[63:3], 3'b000};
      exp_write.wdata = ref_store(ins.op, off, line, ins.rs2_value);
    end
    writes_before = write_count;
    stage_in      = ins;
    @(negedge clk);
    check_ready(name, ins.op == op_none, ready);
    if (flush_it) begin
      @(posedge clk);
      #1;
      syscall_flush = 1'b1;  // Access has started, no done pulse yet
      @(negedge clk);
      check_ready({name, " flush"}, 1'b1, ready);
      @(posedge clk);
      #1;
      syscall_flush = 1'b0;
      check_stage_out({name, " flush"}, '0, stage_out);
      check_cmd({name, " flush"}, cmd_idle, cache_req.cmd);
      prev_out        = '0;
      writes_expected = writes_before;
    end else begin
      while (!ready) begin
        check_stage_out({name, " hold"}, prev_out, stage_out);
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      check_stage_out(name, exp_out, stage_out);
      if (store_op) begin
        ref_mem[idx] = exp_write.wdata;
      end
      prev_out        = exp_out;
      writes_expected = writes_before + (store_op ? 1 : 0);
    end
    if (write_count != writes_expected) begin
      $display("%s: %0d cache writes seen where %0d were expected", name,
               write_count - writes_before, writes_expected - writes_before);
      other_errors++;
    end
  endtask

  initial begin
    stage_in_t  ins;
    logic [3:0] idx;
    logic [2:0] off;
    logic       flush_it;
    void'($urandom(32'h82b6));
    reset         = 1'b1;
    stage_in      = '0;
    syscall_flush = 1'b0;
    cache_rsp     = '0;
    busy          = 1'b0;
    for (int i = 0; i < 16; i++) begin
      cache_mem[i] = {$urandom, $urandom};
      ref_mem[i]   = cache_mem[i];
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    check_stage_out("reset", '0, stage_out);
    check_cmd("reset", cmd_idle, cache_req.cmd);
    prev_out = '0;
    for (int unsigned n = 0; n < num_ops; n++) begin
      idx              = 4'($urandom_range(0, 15));
      off              = 3'($urandom_range(0, 7));
      ins.op           = mem_op_e'(4'($urandom_range(0, 11)));
      ins.rs2_value    = {$urandom, $urandom};
      ins.rd_regno     = regno_t'($urandom);
      ins.update_rd    = 1'($urandom);
      ins.branch_taken = 1'($urandom);
      ins.pc_target    = {$urandom, $urandom};
      if (ins.op == op_none) begin
        ins.alu_result = {$urandom, $urandom};
      end else begin
        ins.alu_result = {57'd0, idx, off};
      end
      flush_it = (ins.op != op_none) && ($urandom_range(0, 15) == 0);
      run_op(ins, flush_it, n);
    end
    $display("Errors: %0d stage_out, %0d cache write, %0d other",
             out_errors, write_errors, other_errors);
    if (out_errors + write_errors + other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
mem_stage_pkg.sv
load_align.sv
store_merge.sv
access_ctrl.sv
mem_stage.sv
tb_clock_gen.sv
mem_stage_properties.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_mem_stage \
  -o sim_mem_stage > build.log 2>&1 \
  && ./obj_dir/sim_mem_stage > sim.log 2>&1 \
  || echo "Build or simulation returned an error, see build.log and sim.log"
grep -q "TEST PASSED" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
